//--- Bender.yml
package:
  name: rv32i_single_cycle

sources:
  - include_dirs:
      - hw
    files:
      - hw/cpu_pkg.sv
      - hw/cpu_ctrl_if.sv
      - hw/control_unit.sv
      - hw/inst_mem.sv
      - hw/reg_file.sv
      - hw/imm_gen.sv
      - hw/alu.sv
      - hw/data_mem.sv
      - hw/cpu_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/cpu_tb.sv

//--- hw/alu.sv
module alu (
    input  logic [31:0] a,
    input  logic [31:0] b,
    cpu_ctrl_if.alu     ctrl,
    output logic [31:0] y
);
    import cpu_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0]; // RV32 shifts use five bits

    always_comb begin
        case (ctrl.alu_op)
            ADD:  y = a + b;
            SUB:  y = a - b;
            SLL:  y = a << shamt;
            SLT:  y = {31'b0, $signed(a) < $signed(b)};
            SLTU: y = {31'b0, a < b};
            XOR:  y = a ^ b;
            SRL:  y = a >> shamt;
            SRA:  y = $unsigned($signed(a) >>> shamt);
            OR:   y = a | b;
            AND:  y = a & b;
            default: y = a + b;
        endcase
    end

endmodule

//--- hw/control_unit.sv
`include "cpu_macros.svh"

module control_unit (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    start,
    input  logic [31:0]             inst,
    cpu_ctrl_if.ctrl                ctrl,
    output logic [`CPU_IMEM_AW-1:0] pc,
    output logic                    halted,
    output logic                    illegal
);
    import cpu_pkg::*;

    run_state_e state;
    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       reg_wr;     // Decoded, before RUN gating
    logic       mem_wr;
    logic       stop;       // ecall, ebreak or unknown opcode
    logic       bad_op;
    logic       reg_we_run;
    logic       mem_we_run;

    // funct3 to ALU operation, alt picks SUB or SRA
    function automatic alu_op_e funct_to_op(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        op = ADD;
        case (f3)
            3'b000: op = alt ? SUB : ADD;
            3'b001: op = SLL;
            3'b010: op = SLT;
            3'b011: op = SLTU;
            3'b100: op = XOR;
            3'b101: op = alt ? SRA : SRL;
            3'b110: op = OR;
            3'b111: op = AND;
            default: op = ADD;
        endcase
        return op;
    endfunction

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        ctrl.alu_op      = ADD;
        ctrl.alu_src_imm = 1'b0;
        ctrl.imm_sel     = IMM_I;
        ctrl.wb_sel      = WB_ALU;
        reg_wr           = 1'b0;
        mem_wr           = 1'b0;
        stop             = 1'b0;
        bad_op           = 1'b0;
        case (opcode)
            OP: begin
                ctrl.alu_op = funct_to_op(funct3, funct7[5]);
                reg_wr      = 1'b1;
            end
            OP_IMM: begin
                // Only the shift-right immediate has an alternate form
                ctrl.alu_op      = funct_to_op(funct3, (funct3 == 3'b101) && funct7[5]);
                ctrl.alu_src_imm = 1'b1;
                reg_wr           = 1'b1;
            end
            LOAD: begin
                ctrl.alu_src_imm = 1'b1; // Address = rs1 + imm
                ctrl.wb_sel      = WB_MEM;
                reg_wr           = 1'b1;
            end
            STORE: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.imm_sel     = IMM_S;
                mem_wr           = 1'b1;
            end
            SYSTEM: stop = 1'b1;
            default: begin
                stop   = 1'b1;
                bad_op = 1'b1;
            end
        endcase
    end

    assign reg_we_run  = reg_wr && (state == RUN);
    assign mem_we_run  = mem_wr && (state == RUN);
    assign ctrl.reg_we = reg_we_run;
    assign ctrl.mem_we = mem_we_run;
    assign halted      = (state == HALT);

    always_ff @(posedge CLK) begin
        if (RST) begin
            state   <= IDLE;
            pc      <= '0;
            illegal <= 1'b0;
        end else begin
            case (state)
                IDLE: if (start) state <= RUN;
                RUN: begin
                    if (stop) begin
                        state   <= HALT; // No pc advance past the halting word
                        illegal <= bad_op;
                    end else begin
                        pc <= pc + 1'b1;
                    end
                end
                default: state <= HALT;
            endcase
        end
    end

    a_we_exclusive: assert property (@(posedge CLK) disable iff (RST)
        !(reg_we_run && mem_we_run));

    a_halt_holds_pc: assert property (@(posedge CLK) disable iff (RST)
        (state == HALT) |=> (state == HALT) && $stable(pc));

endmodule

//--- hw/cpu_ctrl_if.sv
interface cpu_ctrl_if;
    import cpu_pkg::*;

    alu_op_e  alu_op;
    logic     alu_src_imm; // Operand b from immediate
    imm_sel_e imm_sel;
    logic     reg_we;      // Already gated by RUN
    logic     mem_we;      // Already gated by RUN
    wb_sel_e  wb_sel;

    modport ctrl (
        output alu_op,
        output alu_src_imm,
        output imm_sel,
        output reg_we,
        output mem_we,
        output wb_sel
    );

    modport alu (input alu_op);

    modport rf (input reg_we);

    modport mem (input mem_we);

    modport imm (input imm_sel);

endinterface

//--- hw/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Instruction memory geometry
`define CPU_IMEM_DEPTH 64
`define CPU_IMEM_AW    6

// Data memory geometry
`define CPU_DMEM_DEPTH 64
`define CPU_DMEM_AW    6

// Register file geometry, fixed by the ISA
`define CPU_NUM_REGS   32
`define CPU_REG_AW     5

// Word size of the core
`define CPU_XLEN       32

`endif

//--- hw/cpu_pkg.sv
package cpu_pkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011, // R-type ALU
        OP_IMM = 7'b0010011, // I-type ALU
        LOAD   = 7'b0000011, // lw only
        STORE  = 7'b0100011, // sw only
        SYSTEM = 7'b1110011  // ecall / ebreak
    } opcode_e;

    // ALU operations
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3, // Signed compare
        SLTU = 4'd4, // Unsigned compare
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7, // Sign-filling shift
        OR   = 4'd8,
        AND  = 4'd9
    } alu_op_e;

    // Register write-back source
    typedef enum logic {
        WB_ALU = 1'b0,
        WB_MEM = 1'b1
    } wb_sel_e;

    // Immediate format
    typedef enum logic {
        IMM_I = 1'b0,
        IMM_S = 1'b1
    } imm_sel_e;

    // Processor run state
    typedef enum logic [1:0] {
        IDLE = 2'd0, // Waiting for start, loading allowed
        RUN  = 2'd1,
        HALT = 2'd2  // Sticky until reset
    } run_state_e;

endpackage

//--- hw/cpu_top.sv
`include "cpu_macros.svh"

module cpu_top (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    start,
    input  logic                    load_we,
    input  logic [`CPU_IMEM_AW-1:0] load_addr,
    input  logic [31:0]             load_data,
    input  logic [`CPU_REG_AW-1:0]  dbg_addr,
    output logic [31:0]             dbg_data,
    output logic                    halted,
    output logic                    illegal
);
    import cpu_pkg::*;

    logic [`CPU_IMEM_AW-1:0] pc;
    logic [31:0]             inst;
    logic [31:0]             rs1_data;
    logic [31:0]             rs2_data;
    logic [31:0]             imm;
    logic [31:0]             alu_b;
    logic [31:0]             alu_y;
    logic [31:0]             mem_rdata;
    logic [31:0]             wb_data;

    cpu_ctrl_if ctrl_bus ();

    control_unit u_control_unit (
        .CLK     (CLK),
        .RST     (RST),
        .start   (start),
        .inst    (inst),
        .ctrl    (ctrl_bus.ctrl),
        .pc      (pc),
        .halted  (halted),
        .illegal (illegal)
    );

    inst_mem u_inst_mem (
        .CLK       (CLK),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .pc        (pc),
        .inst      (inst)
    );

    reg_file u_reg_file (
        .CLK      (CLK),
        .RST      (RST),
        .rs1      (inst[19:15]),
        .rs2      (inst[24:20]),
        .rd       (inst[11:7]),
        .dbg_addr (dbg_addr),
        .wd       (wb_data),
        .ctrl     (ctrl_bus.rf),
        .rd1      (rs1_data),
        .rd2      (rs2_data),
        .dbg_data (dbg_data)
    );

    imm_gen u_imm_gen (
        .inst (inst),
        .ctrl (ctrl_bus.imm),
        .imm  (imm)
    );

    assign alu_b = ctrl_bus.alu_src_imm ? imm : rs2_data; // Operand b select

    alu u_alu (
        .a    (rs1_data),
        .b    (alu_b),
        .ctrl (ctrl_bus.alu),
        .y    (alu_y)
    );

    data_mem u_data_mem (
        .CLK  (CLK),
        .RST  (RST),
        .addr (alu_y),
        .wd   (rs2_data), // sw stores rs2
        .ctrl (ctrl_bus.mem),
        .rd   (mem_rdata)
    );

    assign wb_data = (ctrl_bus.wb_sel == WB_MEM) ? mem_rdata : alu_y;

endmodule

//--- hw/data_mem.sv
`include "cpu_macros.svh"

module data_mem (
    input  logic        CLK,
    input  logic        RST,
    input  logic [31:0] addr,
    input  logic [31:0] wd,
    cpu_ctrl_if.mem     ctrl,
    output logic [31:0] rd
);

    logic [31:0]             mem [`CPU_DMEM_DEPTH];
    logic [`CPU_DMEM_AW-1:0] word_idx;

    assign word_idx = addr[`CPU_DMEM_AW+1:2]; // Byte address to word

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < `CPU_DMEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (ctrl.mem_we) begin
            mem[word_idx] <= wd;
        end
    end

    assign rd = mem[word_idx];

    // Stores come from sw only, so the ALU address must be aligned
    a_store_aligned: assert property (@(posedge CLK) disable iff (RST)
        ctrl.mem_we |-> (addr[1:0] == 2'b00));

endmodule

//--- hw/imm_gen.sv
module imm_gen (
    input  logic [31:0] inst,
    cpu_ctrl_if.imm     ctrl,
    output logic [31:0] imm
);
    import cpu_pkg::*;

    logic [11:0] field;

    // S format splits the immediate around rs2
    always_comb begin
        case (ctrl.imm_sel)
            IMM_I:   field = inst[31:20];
            IMM_S:   field = {inst[31:25], inst[11:7]};
            default: field = inst[31:20];
        endcase
    end

    assign imm = {{20{field[11]}}, field}; // Sign extend

endmodule

//--- hw/inst_mem.sv
`include "cpu_macros.svh"

module inst_mem (
    input  logic                    CLK,
    input  logic                    load_we,
    input  logic [`CPU_IMEM_AW-1:0] load_addr,
    input  logic [31:0]             load_data,
    input  logic [`CPU_IMEM_AW-1:0] pc,
    output logic [31:0]             inst
);

    logic [31:0] mem [`CPU_IMEM_DEPTH];

    // Program load, word addressed
    always_ff @(posedge CLK) begin
        if (load_we) begin
            mem[load_addr] <= load_data;
        end
    end

    assign inst = mem[pc]; // Combinational fetch

endmodule

//--- hw/reg_file.sv
`include "cpu_macros.svh"

module reg_file (
    input  logic                   CLK,
    input  logic                   RST,
    input  logic [`CPU_REG_AW-1:0] rs1,
    input  logic [`CPU_REG_AW-1:0] rs2,
    input  logic [`CPU_REG_AW-1:0] rd,
    input  logic [`CPU_REG_AW-1:0] dbg_addr,
    input  logic [31:0]            wd,
    cpu_ctrl_if.rf                 ctrl,
    output logic [31:0]            rd1,
    output logic [31:0]            rd2,
    output logic [31:0]            dbg_data
);

    logic [31:0] regs [`CPU_NUM_REGS];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.reg_we && (rd != '0)) begin
            regs[rd] <= wd; // x0 writes dropped
        end
    end

    assign rd1      = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2      = (rs2 == '0) ? '0 : regs[rs2];
    assign dbg_data = (dbg_addr == '0) ? '0 : regs[dbg_addr];

    // x0 storage never picks up a write, whatever the decoder asks for
    a_x0_zero: assert property (@(posedge CLK) disable iff (RST)
        regs[0] == '0);

endmodule

//--- list.f
+incdir+hw
hw/cpu_pkg.sv
hw/cpu_ctrl_if.sv
hw/control_unit.sv
hw/inst_mem.sv
hw/reg_file.sv
hw/imm_gen.sv
hw/alu.sv
hw/data_mem.sv
hw/cpu_top.sv
tb/cpu_tb.sv

//--- tb/cpu_tb.sv
`include "cpu_macros.svh"

module cpu_tb;
    import cpu_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_RANDOM = 20;
    localparam int NUM_TESTS  = 5 + NUM_RANDOM;
    localparam logic [31:0] ECALL_WORD  = 32'h0000_0073;
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;
    localparam logic [31:0] JAL_WORD    = 32'h0000_02ef; // jal x5, unsupported here

    logic                    CLK;
    logic                    RST;
    logic                    start;
    logic                    load_we;
    logic [`CPU_IMEM_AW-1:0] load_addr;
    logic [31:0]             load_data;
    logic [`CPU_REG_AW-1:0]  dbg_addr;
    logic [31:0]             dbg_data;
    logic                    halted;
    logic                    illegal;

    logic [31:0] prog_words [NUM_TESTS*`CPU_IMEM_DEPTH];
    int          prog_len [NUM_TESTS];
    string       test_name [NUM_TESTS];
    int          num_built = 0;
    int          cur = 0;
    logic [31:0] exp_regs [`CPU_NUM_REGS]; // Filled by the software model
    logic        exp_illegal;
    integer      seed = 78;
    int          watchdog_limit = 0;

    cpu_top dut (
        .CLK       (CLK),
        .RST       (RST),
        .start     (start),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .dbg_addr  (dbg_addr),
        .dbg_data  (dbg_data),
        .halted    (halted),
        .illegal   (illegal)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    function automatic logic [31:0] r_type(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP};
    endfunction

    function automatic logic [31:0] i_type(int opc, int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] s_type(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], STORE};
    endfunction

    function automatic int urand(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic new_program(string name);
        test_name[num_built] = name;
        prog_len[num_built]  = 0;
        cur                  = num_built;
        num_built++;
    endtask

    task automatic emit(logic [31:0] w);
        prog_words[cur*`CPU_IMEM_DEPTH + prog_len[cur]] = w;
        prog_len[cur]++;
    endtask

    // RV32I result for one operation, alt selects sub or sra
    function automatic logic [31:0] alu_model(logic [2:0] f3, logic alt,
                                              logic [31:0] a, logic [31:0] b);
        logic [31:0] res;
        case (f3)
            3'd0: res = alt ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: res = (a < b) ? 32'd1 : 32'd0;
            3'd4: res = a ^ b;
            3'd5: begin
                if (alt) res = $signed(a) >>> b[4:0];
                else res = a >> b[4:0];
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    // Runs program t on a software model, returns the cycles up to and including the halt
    function automatic int simulate_program(int t);
        logic [31:0] dmem [`CPU_DMEM_DEPTH];
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        int          pc;
        int          steps;
        bit          done;
        for (int i = 0; i < `CPU_NUM_REGS; i++) exp_regs[i] = '0;
        for (int i = 0; i < `CPU_DMEM_DEPTH; i++) dmem[i] = '0;
        exp_illegal = 1'b0;
        pc          = 0;
        steps       = 0;
        done        = 1'b0;
        while (!done && steps < `CPU_IMEM_DEPTH) begin
            w = prog_words[t*`CPU_IMEM_DEPTH + pc];
            a = exp_regs[w[19:15]];
            b = exp_regs[w[24:20]];
            steps++;
            if (w[6:0] == OP) begin
                exp_regs[w[11:7]] = alu_model(w[14:12], w[30], a, b);
            end else if (w[6:0] == OP_IMM) begin
                // Only srai uses the high immediate bit as a selector
                exp_regs[w[11:7]] = alu_model(w[14:12], (w[14:12] == 3'd5) && w[30], a,
                                              {{20{w[31]}}, w[31:20]});
            end else if (w[6:0] == LOAD) begin
                addr = a + {{20{w[31]}}, w[31:20]};
                exp_regs[w[11:7]] = dmem[addr[7:2]];
            end else if (w[6:0] == STORE) begin
                addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                dmem[addr[7:2]] = b;
            end else if (w[6:0] == SYSTEM) begin
                done = 1'b1;
            end else begin
                done        = 1'b1;
                exp_illegal = 1'b1;
            end
            exp_regs[0] = '0;
            pc = (pc + 1) % `CPU_IMEM_DEPTH;
        end
        return steps;
    endfunction

    task automatic build_directed();
        new_program("r_type");
        emit(i_type(OP_IMM, 0, 1, 0, -5));
        emit(i_type(OP_IMM, 0, 2, 0, 7));
        emit(i_type(OP_IMM, 0, 3, 0, -2048));
        emit(i_type(OP_IMM, 0, 4, 0, 3));
        emit(r_type(0, 0, 5, 1, 2));       // add
        emit(r_type(32, 0, 6, 1, 2));      // sub
        emit(r_type(0, 1, 7, 2, 4));       // sll
        emit(r_type(0, 2, 8, 1, 2));       // slt, negative less
        emit(r_type(0, 3, 9, 1, 2));       // sltu, negative is huge
        emit(r_type(0, 4, 10, 1, 2));
        emit(r_type(0, 5, 11, 1, 4));      // srl
        emit(r_type(32, 5, 12, 1, 4));     // sra
        emit(r_type(0, 6, 13, 1, 3));
        emit(r_type(0, 7, 14, 1, 2));
        emit(r_type(0, 2, 15, 2, 1));
        emit(r_type(0, 3, 16, 2, 1));
        emit(r_type(32, 0, 17, 3, 2));
        emit(ECALL_WORD);

        new_program("i_type");
        emit(i_type(OP_IMM, 0, 1, 0, -100));
        emit(i_type(OP_IMM, 0, 2, 1, -1));
        emit(i_type(OP_IMM, 2, 3, 1, -50));  // slti
        emit(i_type(OP_IMM, 3, 4, 1, -1));   // sltiu against all ones
        emit(i_type(OP_IMM, 4, 5, 1, -1));   // xori, bitwise not
        emit(i_type(OP_IMM, 6, 6, 1, 'h0f0));
        emit(i_type(OP_IMM, 7, 7, 1, -16));
        emit(i_type(OP_IMM, 1, 8, 1, 7));    // slli
        emit(i_type(OP_IMM, 5, 9, 1, 3));    // srli
        emit(i_type(OP_IMM, 5, 10, 1, 'h403)); // srai by 3
        emit(i_type(OP_IMM, 1, 11, 2, 31));  // Odd source leaves only the sign bit
        emit(i_type(OP_IMM, 5, 12, 11, 'h41f));
        emit(EBREAK_WORD);

        new_program("load_store");
        emit(i_type(OP_IMM, 0, 1, 0, -123));
        emit(i_type(OP_IMM, 0, 2, 0, 'h555));
        emit(i_type(OP_IMM, 0, 3, 0, 16)); // Base address
        emit(i_type(OP_IMM, 0, 4, 0, 200));
        emit(s_type(1, 3, 0));
        emit(s_type(2, 3, 4));
        emit(s_type(1, 0, 252));           // Last data word
        emit(s_type(4, 3, -8));
        emit(i_type(LOAD, 2, 5, 3, 0));
        emit(i_type(LOAD, 2, 6, 3, 4));
        emit(i_type(LOAD, 2, 7, 0, 252));
        emit(i_type(LOAD, 2, 8, 0, 8));
        emit(i_type(LOAD, 2, 9, 0, 12));   // Never written
        emit(ECALL_WORD);

        new_program("x0_writes");
        emit(i_type(OP_IMM, 0, 1, 0, 9));
        emit(i_type(OP_IMM, 0, 0, 0, 55));
        emit(s_type(1, 0, 0));
        emit(i_type(LOAD, 2, 0, 0, 0));    // lw into x0
        emit(i_type(OP_IMM, 0, 0, 1, 1));
        emit(i_type(OP_IMM, 1, 0, 1, 2));
        emit(r_type(0, 0, 2, 0, 1));
        emit(i_type(LOAD, 2, 3, 0, 0));
        emit(ECALL_WORD);

        new_program("illegal_opcode");
        emit(i_type(OP_IMM, 0, 1, 0, 11));
        emit(i_type(OP_IMM, 0, 2, 0, 22));
        emit(JAL_WORD);
        emit(i_type(OP_IMM, 0, 3, 0, 33)); // Must stay unexecuted
        emit(ECALL_WORD);
    endtask

    task automatic build_random(int n);
        int len;
        int kind;
        int f3;
        int imm;
        new_program($sformatf("random_%0d", n));
        for (int r = 1; r < 8; r++) emit(i_type(OP_IMM, 0, r, 0, urand(4096)));
        len = 10 + urand(20);
        for (int k = 0; k < len; k++) begin
            kind = urand(10);
            f3   = urand(8);
            if (kind < 5) begin
                emit(r_type(((f3 == 0 || f3 == 5) && urand(2) == 1) ? 32 : 0, f3,
                            urand(8), urand(8), urand(8)));
            end else if (kind < 8) begin
                if (f3 == 1) imm = urand(32);
                else if (f3 == 5) imm = urand(32) + 'h400 * urand(2);
                else imm = urand(4096);
                emit(i_type(OP_IMM, f3, urand(8), urand(8), imm));
            end else if (kind == 8) begin
                emit(i_type(LOAD, 2, urand(8), 0, 4 * urand(64)));
            end else begin
                emit(s_type(urand(8), 0, 4 * urand(64)));
            end
        end
        emit(ECALL_WORD);
    endtask

    task automatic compare_word(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic reset_dut();
        @(posedge CLK);
        #1 RST = 1'b1;
        repeat (4) @(posedge CLK);
        #1 RST = 1'b0;
    endtask

    task automatic load_program(int t);
        for (int i = 0; i < prog_len[t]; i++) begin
            @(posedge CLK);
            #1;
            load_we   = 1'b1;
            load_addr = i[`CPU_IMEM_AW-1:0];
            load_data = prog_words[t*`CPU_IMEM_DEPTH + i];
        end
    endtask

    task automatic run_test(int t);
        int exp_cycles;
        int cycles;
        exp_cycles = simulate_program(t);
        reset_dut();
        load_program(t);
        @(posedge CLK);
        #1;
        load_we = 1'b0;
        start   = 1'b1;
        @(posedge CLK);
        #1 start = 1'b0;
        cycles = 0;
        while (!halted) begin // Watchdog bounds this loop
            @(posedge CLK);
            #1 cycles++;
        end
        compare_word({test_name[t], " halt cycles"}, exp_cycles, cycles);
        compare_word({test_name[t], " illegal"}, {31'b0, exp_illegal}, {31'b0, illegal});
        repeat (2) @(posedge CLK); // Any late write would land here
        for (int i = 0; i < `CPU_NUM_REGS; i++) begin
            @(posedge CLK);
            #1 dbg_addr = i[`CPU_REG_AW-1:0];
            #1 compare_word($sformatf("%s x%0d", test_name[t], i), exp_regs[i], dbg_data);
        end
        compare_word({test_name[t], " halted held"}, 32'd1, {31'b0, halted});
    endtask

    initial begin
        int budget_cycles;
        RST       = 1'b1;
        start     = 1'b0;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        dbg_addr  = '0;
        build_directed();
        for (int n = 0; n < NUM_RANDOM; n++) build_random(n);
        budget_cycles = 0;
        for (int t = 0; t < NUM_TESTS; t++) budget_cycles += prog_len[t] + 20;
        watchdog_limit = budget_cycles * 4 * CLK_PERIOD;
        for (int t = 0; t < NUM_TESTS; t++) run_test(t);
        $display("SIMULATION PASSED");
        $finish;
    end

    // Generous bound, a test needs about twice its length plus 45 cycles
    initial begin
        wait (watchdog_limit > 0);
        #(watchdog_limit);
        $display("Timeout: the processor never halted within %0d time units", watchdog_limit);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule
